// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := fcvt_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
+incdir+include
logic/fcvt_pkg.sv
logic/fcvt_intf.sv
logic/int_operand_prep.sv
logic/lead_zero_count.sv
logic/int_to_fp_convert.sv
logic/fp_round_pack.sv
logic/fcvt_top.sv
tb/fcvt_assertions.sv
tb/fcvt_tb.sv

// ==== include/fcvt_consts.svh ====
// Single-precision widths only; changing these values is not a supported way to get other formats
`ifndef FCVT_CONSTS_SVH
`define FCVT_CONSTS_SVH

////////////////////////////////////////
// Integer side

`define FCVT_XLEN 32        // Operand width of FCVT.S.W / FCVT.S.WU

`define FCVT_ID_WIDTH 4     // Request tag carried to writeback

////////////////////////////////////////
// IEEE-754 binary32 fields

`define FCVT_EXPO_WIDTH 8   // Biased exponent

`define FCVT_FRAC_WIDTH 23  // Stored fraction, hidden bit dropped

// Exponent bias
`define FCVT_BIAS 127

`endif

// ==== logic/fcvt_intf.sv ====
// Stage buses with a plain valid strobe and no ready; payload is meaningful only while valid is high
`default_nettype none

`include "fcvt_consts.svh"

////////////////////////////////////////
// Input side to processing part

interface operand_if;
    logic                      valid;      // One-cycle strobe per request
    logic [`FCVT_ID_WIDTH-1:0] id;
    logic                      sign;       // Set only for a negative signed operand
    logic [`FCVT_XLEN-1:0]     abs_val;    // Magnitude, 2^31 for the most negative int
    logic                      zero;
    fcvt_pkg::round_mode_t     rm;

    modport src (output valid, id, sign, abs_val, zero, rm);
    modport dst (input  valid, id, sign, abs_val, zero, rm);
endinterface

////////////////////////////////////////
// Processing part to output side

interface unrounded_if;
    logic                        valid;
    logic [`FCVT_ID_WIDTH-1:0]   id;
    logic                        sign;
    logic                        zero;
    logic [`FCVT_EXPO_WIDTH-1:0] expo;      // Biased, before any rounding carry
    logic [`FCVT_FRAC_WIDTH-1:0] mant;      // Bits below the leading one
    logic                        round_bit; // First bit dropped
    logic                        sticky;    // OR of everything under round_bit
    fcvt_pkg::round_mode_t       rm;

    modport src (output valid, id, sign, zero, expo, mant, round_bit, sticky, rm);
    modport dst (input  valid, id, sign, zero, expo, mant, round_bit, sticky, rm);
endinterface

`default_nettype wire

// ==== logic/fcvt_pkg.sv ====
// Types for the binary32 convert path; rounding modes 5 to 7 are not legal and are not handled
`default_nettype none

`include "fcvt_consts.svh"

package fcvt_pkg;

    // RISC-V rm field encodings
    typedef enum logic [2:0] {
        rne = 3'd0,             // Nearest, ties to even
        rtz = 3'd1,             // Toward zero
        rdn = 3'd2,             // Toward minus infinity
        rup = 3'd3,             // Toward plus infinity
        rmm = 3'd4              // Nearest, ties away from zero
    } round_mode_t;

    // Field layout of a binary32 word, MSB first
    typedef struct packed {
        logic                        sign;
        logic [`FCVT_EXPO_WIDTH-1:0] expo;
        logic [`FCVT_FRAC_WIDTH-1:0] frac;
    } fp_fields_t;

    // Result word, seen either as raw bits or as fields
    typedef union packed {
        logic [`FCVT_EXPO_WIDTH+`FCVT_FRAC_WIDTH:0] raw;
        fp_fields_t                                 fields;
    } fp_word_u;

endpackage

`default_nettype wire

// ==== logic/fcvt_top.sv ====
// Two-clock FCVT.S.W/WU unit without back-pressure; every done must be taken the cycle it appears
`default_nettype none

`include "fcvt_consts.svh"

module fcvt_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       new_request,
    input  logic [`FCVT_ID_WIDTH-1:0]                  req_id,
    input  logic [`FCVT_XLEN-1:0]                      int_rs1,
    input  logic                                       is_signed,
    input  fcvt_pkg::round_mode_t                      rm,
    output logic                                       done,
    output logic [`FCVT_ID_WIDTH-1:0]                  wb_id,
    output logic [`FCVT_EXPO_WIDTH+`FCVT_FRAC_WIDTH:0] wb_rd,
    output logic                                       wb_inexact
);

    operand_if   opnd_bus ();     // Registered operand, one cycle after request
    unrounded_if unrnd_bus ();    // Same cycle as opnd_bus

    ////////////////////////////////////////
    // Stages

    int_operand_prep prep_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .new_request (new_request),
        .req_id      (req_id),
        .int_rs1     (int_rs1),
        .is_signed   (is_signed),
        .rm          (rm),
        .opnd        (opnd_bus.src)
    );

    int_to_fp_convert convert_inst (
        .opnd  (opnd_bus.dst),
        .unrnd (unrnd_bus.src)
    );

    fp_round_pack round_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .unrnd      (unrnd_bus.dst),
        .done       (done),
        .wb_id      (wb_id),
        .wb_rd      (wb_rd),
        .wb_inexact (wb_inexact)
    );

endmodule

`default_nettype wire

// ==== logic/fp_round_pack.sv ====
// Rounds and registers one result per strobe; rm codes 5 to 7 truncate and overflow cannot occur
`default_nettype none

`include "fcvt_consts.svh"

module fp_round_pack (
    input  logic                                       clk,
    input  logic                                       rst_n,
    unrounded_if.dst                                   unrnd,
    output logic                                       done,
    output logic [`FCVT_ID_WIDTH-1:0]                  wb_id,
    output logic [`FCVT_EXPO_WIDTH+`FCVT_FRAC_WIDTH:0] wb_rd,
    output logic                                       wb_inexact
);

    logic                        round_up;
    logic [`FCVT_FRAC_WIDTH:0]   mant_sum;   // Extra bit catches the carry out
    logic [`FCVT_EXPO_WIDTH-1:0] expo_rnd;
    logic                        inexact;
    fcvt_pkg::fp_word_u          result;

    ////////////////////////////////////////
    // Increment decision

    always_comb begin
        case (unrnd.rm)
            fcvt_pkg::rne: round_up = unrnd.round_bit & (unrnd.sticky | unrnd.mant[0]);
            fcvt_pkg::rtz: round_up = 1'b0;
            fcvt_pkg::rdn: round_up = unrnd.sign & (unrnd.round_bit | unrnd.sticky);
            fcvt_pkg::rup: round_up = ~unrnd.sign & (unrnd.round_bit | unrnd.sticky);
            fcvt_pkg::rmm: round_up = unrnd.round_bit;    // Ties go away from zero
            default:       round_up = 1'b0;
        endcase
    end

    // A carry leaves the fraction at zero and moves into the exponent
    assign mant_sum = {1'b0, unrnd.mant} + {{`FCVT_FRAC_WIDTH{1'b0}}, round_up};
    assign expo_rnd = unrnd.expo
                    + {{(`FCVT_EXPO_WIDTH-1){1'b0}}, mant_sum[`FCVT_FRAC_WIDTH]};

    assign inexact = unrnd.round_bit | unrnd.sticky;

    ////////////////////////////////////////
    // Pack through the field view

    always_comb begin
        if (unrnd.zero) begin
            result.raw = '0;                            // Always +0.0
        end else begin
            result.fields.sign = unrnd.sign;
            result.fields.expo = expo_rnd;
            result.fields.frac = mant_sum[`FCVT_FRAC_WIDTH-1:0];
        end
    end

    ////////////////////////////////////////
    // Writeback register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done       <= 1'b0;
            wb_id      <= '0;
            wb_rd      <= '0;
            wb_inexact <= 1'b0;
        end else begin
            done <= unrnd.valid;
            if (unrnd.valid) begin                      // Hold the last result between strobes
                wb_id      <= unrnd.id;
                wb_rd      <= result.raw;
                wb_inexact <= inexact;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/int_operand_prep.sv ====
// One register stage; a request is taken every cycle that new_request is high, no stall exists
`default_nettype none

`include "fcvt_consts.svh"

module int_operand_prep (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      new_request,
    input  logic [`FCVT_ID_WIDTH-1:0] req_id,
    input  logic [`FCVT_XLEN-1:0]     int_rs1,
    input  logic                      is_signed,
    input  fcvt_pkg::round_mode_t     rm,
    operand_if.src                    opnd
);

    logic                  rs1_sign;
    logic [`FCVT_XLEN-1:0] rs1_abs;
    logic                  rs1_zero;

    ////////////////////////////////////////
    // Sign and magnitude

    assign rs1_sign = is_signed & int_rs1[`FCVT_XLEN-1];   // FCVT.S.WU is never negative
    // Negating 0x8000_0000 wraps back to itself, which reads as 2^31 unsigned
    assign rs1_abs  = rs1_sign ? (~int_rs1 + 1'b1) : int_rs1;
    assign rs1_zero = (int_rs1 == '0);                       // Saves a compare downstream

    ////////////////////////////////////////
    // Stage register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opnd.valid <= 1'b0;
        end else begin
            opnd.valid <= new_request;       // Strobe stays one cycle wide
        end
    end

    // Payload only moves with a request
    always_ff @(posedge clk) begin
        if (new_request) begin
            opnd.id      <= req_id;
            opnd.sign    <= rs1_sign;
            opnd.abs_val <= rs1_abs;
            opnd.zero    <= rs1_zero;
            opnd.rm      <= rm;
        end
    end

endmodule

`default_nettype wire

// ==== logic/int_to_fp_convert.sv ====
// Purely combinational; assumes the integer is wider than the fraction, so round and sticky bits exist
`default_nettype none

`include "fcvt_consts.svh"

module int_to_fp_convert (
    operand_if.dst   opnd,
    unrounded_if.src unrnd
);

    logic [4:0]                  clz;
    logic [5:0]                  shamt;      // Reaches 32, one bit wider than clz
    logic [`FCVT_XLEN-1:0]       shifted;
    logic [`FCVT_EXPO_WIDTH-1:0] expo_norm;

    lead_zero_count lzc_inst (
        .value (opnd.abs_val),
        .count (clz)
    );

    ////////////////////////////////////////
    // Normalize

    // Shift one past the leading one so the hidden bit falls off the top
    assign shamt   = {1'b0, clz} + 6'd1;
    assign shifted = opnd.abs_val << shamt;

    // Leading one at bit 31-clz gives exponent bias + 31 - clz
    assign expo_norm = `FCVT_EXPO_WIDTH'(`FCVT_BIAS + `FCVT_XLEN - 1)
                     - {{(`FCVT_EXPO_WIDTH-5){1'b0}}, clz};

    ////////////////////////////////////////
    // Unrounded result

    assign unrnd.expo      = opnd.zero ? '0 : expo_norm;              // Zero has no leading one
    assign unrnd.mant      = shifted[`FCVT_XLEN-1 -: `FCVT_FRAC_WIDTH];
    assign unrnd.round_bit = shifted[`FCVT_XLEN-1-`FCVT_FRAC_WIDTH];
    assign unrnd.sticky    = |shifted[`FCVT_XLEN-2-`FCVT_FRAC_WIDTH:0]; // All lower dropped bits

    // Control and tag ride along untouched
    assign unrnd.valid = opnd.valid;
    assign unrnd.id    = opnd.id;
    assign unrnd.sign  = opnd.sign;
    assign unrnd.zero  = opnd.zero;
    assign unrnd.rm    = opnd.rm;

endmodule

`default_nettype wire

// ==== logic/lead_zero_count.sv ====
// Fixed 32-bit leading-zero count; an all-zero input reports 31, callers must flag zero themselves
`default_nettype none

`include "fcvt_consts.svh"

module lead_zero_count (
    input  logic [`FCVT_XLEN-1:0] value,
    output logic [4:0]            count
);

    logic [15:0] half;     // Upper or lower 16 bits, whichever holds the leading one
    logic [7:0]  quarter;
    logic [3:0]  eighth;
    logic [1:0]  pair;

    // Each level asks whether the upper half is empty and keeps the half to search next
    assign count[4] = ~|value[31:16];
    assign half     = count[4] ? value[15:0] : value[31:16];

    assign count[3] = ~|half[15:8];
    assign quarter  = count[3] ? half[7:0] : half[15:8];

    assign count[2] = ~|quarter[7:4];
    assign eighth   = count[2] ? quarter[3:0] : quarter[7:4];

    assign count[1] = ~|eighth[3:2];
    assign pair     = count[1] ? eighth[1:0] : eighth[3:2];

    // Last bit needs no select
    assign count[0] = ~pair[1];

endmodule

`default_nettype wire

// ==== tb/fcvt_assertions.sv ====
// Sampled at rising clk; assumes the fixed two-clock pipeline with no stall and an async reset
`default_nettype none

module fcvt_assertions (
    input logic        clk,
    input logic        rst_n,
    input logic        new_request,
    input logic        done,
    input logic [31:0] wb_rd,
    input logic        wb_inexact
);

    ////////////////////////////////////////
    // Strobe timing

    a_req_to_done: assert property (
        @(posedge clk) disable iff (!rst_n) new_request |-> ##2 done
    ) else $error("done did not follow a request by two cycles");

    // No done without a request two cycles back
    a_done_from_req: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> $past(new_request, 2)
    ) else $error("done raised without a matching request");

    ////////////////////////////////////////
    // Reset and result sanity

    a_reset_quiet: assert property (
        @(posedge clk) !rst_n |-> !done
    ) else $error("done high during reset");

    a_zero_exact: assert property (
        @(posedge clk) disable iff (!rst_n) (wb_rd == 32'd0) |-> !wb_inexact
    ) else $error("inexact set on a zero result");   // +0.0 is always exact

endmodule

`default_nettype wire

// ==== tb/fcvt_tb.sv ====
// Needs a simulator with timing support; tags repeat, so order is checked through the queue
`default_nettype none

`include "fcvt_consts.svh"

module fcvt_tb;

    localparam int TIMEOUT = 20;              // Cycles allowed for outstanding results

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      new_request;
    logic [`FCVT_ID_WIDTH-1:0] req_id;
    logic [`FCVT_XLEN-1:0]     int_rs1;
    logic                      is_signed;
    fcvt_pkg::round_mode_t     rm;
    logic                      done;
    logic [`FCVT_ID_WIDTH-1:0] wb_id;
    logic [31:0]               wb_rd;
    logic                      wb_inexact;

    integer      seed = 32'h72f6baa9;
    int          cyc = 0;                     // Rising edges so far
    int          checks = 0;
    int          errors = 0;
    int          test_base = 0;
    logic [36:0] exp_q[$];                    // {tag, inexact, word} in issue order
    int          issue_q[$];                  // cyc when each request was driven

    fcvt_top dut_i (
        .clk(clk), .rst_n(rst_n), .new_request(new_request), .req_id(req_id),
        .int_rs1(int_rs1), .is_signed(is_signed), .rm(rm),
        .done(done), .wb_id(wb_id), .wb_rd(wb_rd), .wb_inexact(wb_inexact)
    );

    bind fcvt_top fcvt_assertions assert_i (
        .clk(clk), .rst_n(rst_n), .new_request(new_request),
        .done(done), .wb_rd(wb_rd), .wb_inexact(wb_inexact)
    );

    always #10 clk = ~clk;                    // Period 20
    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    ////////////////////////////////////////
    // Reference model built from the conversion and rounding rules

    function automatic logic [32:0] model(input logic [31:0] val, input logic sgn,
                                          input logic [2:0] mode);
        fcvt_pkg::fp_word_u word;
        logic        neg;
        logic [31:0] mag;
        logic [22:0] frac;
        logic        rnd;
        logic        stk;
        logic        inc;
        logic [23:0] sum;
        int          p;
        neg = sgn & val[31];
        mag = neg ? -val : val;               // 0x8000_0000 stays 2^31
        if (mag == 32'd0) return 33'd0;       // Zero converts exactly to +0.0
        p = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) begin
                p = i;                        // Leading one
            end
        end
        if (p <= 23) begin
            frac = 23'(mag << (23 - p));
            rnd  = 1'b0;
            stk  = 1'b0;
        end else begin
            frac = 23'(mag >> (p - 23));
            rnd  = mag[p - 24];
            stk  = |(mag & ((32'd1 << (p - 24)) - 32'd1));
        end
        case (mode)
            fcvt_pkg::rne: inc = rnd & (stk | frac[0]);
            fcvt_pkg::rdn: inc = neg & (rnd | stk);
            fcvt_pkg::rup: inc = ~neg & (rnd | stk);
            fcvt_pkg::rmm: inc = rnd;
            default:       inc = 1'b0;        // rtz
        endcase
        sum = {1'b0, frac} + {23'd0, inc};
        word.fields.sign = neg;
        word.fields.expo = 8'(p + `FCVT_BIAS) + {7'd0, sum[23]};   // Carry bumps exponent
        word.fields.frac = sum[22:0];
        return {rnd | stk, word.raw};
    endfunction

    ////////////////////////////////////////
    // Cycle driver and scoreboard

    task automatic collect();
        logic [36:0] want;
        if (done) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("A done strobe arrived at time %0t with no request outstanding", $time);
            end else begin
                want = exp_q.pop_front();
                check_value(wb_rd, want[31:0], "result word");
                check_value({31'd0, wb_inexact}, {31'd0, want[32]}, "inexact flag");
                check_value({28'd0, wb_id}, {28'd0, want[36:33]}, "tag");
                check_value(32'(cyc - issue_q.pop_front()), 32'd2, "latency");
            end
        end
    endtask

    // Check outputs on a falling edge and then drive the next inputs
    task automatic step(input logic req, input logic [31:0] val, input logic sgn,
                        input logic [2:0] mode, input logic [32:0] want);
        logic [3:0] tag;
        @(negedge clk);
        collect();
        tag         = 4'($random(seed));
        new_request = req;
        req_id      = tag;
        int_rs1     = val;
        is_signed   = sgn;
        rm          = fcvt_pkg::round_mode_t'(mode);
        if (req) begin
            exp_q.push_back({tag, want});
            issue_q.push_back(cyc);
        end
    endtask

    task automatic convert(input logic [31:0] val, input logic sgn, input logic [2:0] mode);
        step(1'b1, val, sgn, mode, model(val, sgn, mode));
    endtask

    // Hand-computed result that does not come from the model
    task automatic known(input logic [31:0] val, input logic sgn, input logic [2:0] mode,
                         input logic inx, input logic [31:0] word);
        step(1'b1, val, sgn, mode, {inx, word});
    endtask

    task automatic idle();
        step(1'b0, 32'd0, 1'b0, 3'd0, 33'd0);
    endtask

    task automatic drain_and_report(input string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            idle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout: %0d requests never produced a done", exp_q.size());
            exp_q.delete();
            issue_q.delete();
        end
        $display("%s finished with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        logic [31:0] mag;
        logic        sgn;
        rst_n       = 1'b0;
        new_request = 1'b0;
        req_id      = '0;
        int_rs1     = '0;
        is_signed   = 1'b0;
        rm          = fcvt_pkg::rne;
        repeat (4) @(negedge clk);            // Four rising edges in reset
        rst_n = 1'b1;
        check_value({31'd0, done}, 32'd0, "done after reset");

        known(32'd0, 1'b0, fcvt_pkg::rne, 1'b0, 32'h0000_0000);
        known(32'd0, 1'b1, fcvt_pkg::rup, 1'b0, 32'h0000_0000);
        known(32'd1, 1'b0, fcvt_pkg::rne, 1'b0, 32'h3f80_0000);
        known(32'd2, 1'b1, fcvt_pkg::rdn, 1'b0, 32'h4000_0000);
        known(32'd3, 1'b0, fcvt_pkg::rtz, 1'b0, 32'h4040_0000);
        known(32'd100, 1'b1, fcvt_pkg::rmm, 1'b0, 32'h42c8_0000);
        known(32'h00ff_ffff, 1'b0, fcvt_pkg::rup, 1'b0, 32'h4b7f_ffff);  // Largest exact
        repeat (10) convert({$random(seed)} & 32'h00ff_ffff, 1'(($random(seed))), 3'd0);
        drain_and_report("exact small integers");

        known(32'hffff_ffff, 1'b1, fcvt_pkg::rne, 1'b0, 32'hbf80_0000);  // -1
        known(32'hffff_fffe, 1'b1, fcvt_pkg::rtz, 1'b0, 32'hc000_0000);  // -2
        known(32'hffff_ff9c, 1'b1, fcvt_pkg::rup, 1'b0, 32'hc2c8_0000);  // -100
        known(32'h8000_0000, 1'b1, fcvt_pkg::rne, 1'b0, 32'hcf00_0000);  // Most negative
        known(32'h8000_0000, 1'b0, fcvt_pkg::rne, 1'b0, 32'h4f00_0000);
        known(32'hffff_ffff, 1'b0, fcvt_pkg::rne, 1'b1, 32'h4f80_0000);
        known(32'hffff_ffff, 1'b0, fcvt_pkg::rtz, 1'b1, 32'h4f7f_ffff);
        drain_and_report("negative and unsigned patterns");

        for (int m = 0; m < 5; m++) begin
            repeat (20) begin
                mag = ({$random(seed)} & 32'h7fff_ffff) | 32'h0100_0000;   // Over 24 bits
                sgn = 1'($random(seed));
                convert((sgn & mag[0]) ? -mag : mag, sgn, 3'(m));
            end
        end
        drain_and_report("wide operands in all rounding modes");

        known(32'h0100_0001, 1'b0, fcvt_pkg::rne, 1'b1, 32'h4b80_0000);  // Tie keeps even
        known(32'h0100_0001, 1'b0, fcvt_pkg::rmm, 1'b1, 32'h4b80_0001);  // Tie rounds away
        known(32'h0100_0003, 1'b0, fcvt_pkg::rne, 1'b1, 32'h4b80_0002);  // Odd tie rounds up
        known(32'h01ff_ffff, 1'b0, fcvt_pkg::rtz, 1'b1, 32'h4bff_ffff);
        known(32'h01ff_ffff, 1'b0, fcvt_pkg::rne, 1'b1, 32'h4c00_0000);  // Carry into expo
        known(32'hfeff_ffff, 1'b1, fcvt_pkg::rup, 1'b1, 32'hcb80_0000);  // -(2^24+1)
        known(32'hfeff_ffff, 1'b1, fcvt_pkg::rdn, 1'b1, 32'hcb80_0001);
        drain_and_report("halfway and carry cases");

        repeat (30) convert($random(seed), 1'($random(seed)), 3'({$random(seed)} % 5));
        repeat (30) begin
            convert($random(seed), 1'($random(seed)), 3'({$random(seed)} % 5));
            repeat ({$random(seed)} % 4) idle();
        end
        drain_and_report("back-to-back and gapped requests");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
